// ==== udp_sample_tx.f ====
net_cfg_pkg.sv
udp_frame_pkg.sv
seg7_decoder.sv
tx_status_display.sv
sample_framer.sv
udp_sample_tx.sv
udp_sample_tx_assert.sv
tb_udp_sample_tx.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_udp_sample_tx
FILELIST  ?= udp_sample_tx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then \
		echo "Simulation reported failure"; exit 1; fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_udp_sample_tx.sv ====
`timescale 1ns/1ps

module tb_udp_sample_tx
    import net_cfg_pkg::*;
    import udp_frame_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS = 6;
    localparam int MAX_STALL = 3;
    localparam int TIMEOUT_CYCLES =
        NUM_TESTS * (1 + PAYLOAD_BYTES) * (MAX_STALL + 1) + RESET_CYCLES + 100;

    typedef struct packed {
        logic [15:0] m;
        logic [15:0] n;
        logic [15:0] adc_data;
        logic [3:0]  stall;
        logic        extra_pulse;
    } stim_entry_t;

    // m, n, adc_data, longest ready stall, extra adc_valid mid-frame
    localparam stim_entry_t STIM_TABLE [NUM_TESTS] = '{
        '{16'h1234, 16'h5678, 16'h9abc, 4'd0, 1'b0},
        '{16'ha5a5, 16'h5a5a, 16'h0ff0, 4'd1, 1'b0},
        '{16'hffff, 16'h0000, 16'h8001, 4'd2, 1'b1},
        '{16'h00ff, 16'hff00, 16'h7e7e, 4'd3, 1'b0},
        '{16'hdead, 16'hbeef, 16'hcafe, 4'd3, 1'b1},
        '{16'h0001, 16'h8000, 16'h4321, 4'd0, 1'b1}
    };

    // Hex glyphs, segment a in bit 0
    localparam logic [6:0] GLYPH [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    logic            clk;
    logic            rst;
    logic            adc_valid;
    adc_sample_t     sample;
    logic            hdr_ready;
    logic            payload_ready;
    udp_hdr_t        hdr;
    logic            hdr_valid;
    payload_beat_t   payload;
    logic            payload_valid;
    logic [8:0]      ledg;
    logic [7:0][6:0] hex;

    int          seed = 32'h1bef_b1bf;
    logic [31:0] rand_bits;
    int          stall_limit = 0;
    int          hdr_stall = 0;
    int          payload_stall = 0;

    int error_count = 0;
    int cycle_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int errs_before;

    // Monitor bookkeeping for the frame in flight
    int          frames_done = 0;
    int          hdr_count = 0;
    int          byte_idx = 0;
    bit          hdr_seen = 1'b0;
    bit          frame_open = 1'b0;
    logic [7:0]  exp_bytes [PAYLOAD_BYTES];
    stim_entry_t cur;

    udp_sample_tx u_dut (
        .clk           (clk),
        .rst           (rst),
        .adc_valid     (adc_valid),
        .sample        (sample),
        .hdr           (hdr),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .payload       (payload),
        .payload_valid (payload_valid),
        .payload_ready (payload_ready),
        .ledg          (ledg),
        .hex           (hex)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("ERROR t=%0t: %s", $time, what);
            error_count++;
        end
    endtask

    // Active-low digit pattern for one nibble
    function automatic logic [6:0] expected_digit(input logic [3:0] nib);
        return ~GLYPH[nib];
    endfunction

    task automatic check_display(input logic [7:0] first_byte);
        check_value("ledg[7:0]", ledg[7:0], first_byte);
        for (int k = 0; k < 8; k++) begin
            check_value($sformatf("hex[%0d]", k), hex[k],
                        expected_digit(DEFAULT_DEST_IP[4*k +: 4]));
        end
    endtask

    task automatic finish_test(input string label, input int errs);
        if (error_count == errs) begin
            tests_passed++;
            $display("%s: passed", label);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", label, error_count - errs);
        end
    endtask

    // Random ready, never low for more than stall_limit cycles in a row
    always @(posedge clk) begin
        #2;
        rand_bits = $random(seed);
        if (hdr_stall >= stall_limit || rand_bits[0]) begin
            hdr_ready = 1'b1;
            hdr_stall = 0;
        end else begin
            hdr_ready = 1'b0;
            hdr_stall++;
        end
        if (payload_stall >= stall_limit || rand_bits[1]) begin
            payload_ready = 1'b1;
            payload_stall = 0;
        end else begin
            payload_ready = 1'b0;
            payload_stall++;
        end
    end

    // Transfers are seen at the falling edge before the edge that takes them
    always @(negedge clk) begin
        if (!rst) begin
            check_value("ledg[8]", ledg[8], frame_open);
            if (hdr_valid && hdr_ready) begin
                check_true(!hdr_seen, "second header inside one frame");
                check_value("hdr.ttl", hdr.ttl, DEFAULT_TTL);
                check_value("hdr.source_ip", hdr.source_ip, DEFAULT_SRC_IP);
                check_value("hdr.dest_ip", hdr.dest_ip, DEFAULT_DEST_IP);
                check_value("hdr.source_port", hdr.source_port, DEFAULT_SRC_PORT);
                check_value("hdr.dest_port", hdr.dest_port, DEFAULT_DEST_PORT);
                check_value("hdr.length", hdr.length, 8 + PAYLOAD_BYTES);
                hdr_seen = 1'b1;
                hdr_count++;
            end
            if (payload_valid && payload_ready) begin
                check_true(hdr_seen, "payload byte sent before its header");
                if (byte_idx < PAYLOAD_BYTES) begin
                    check_value("payload.data", payload.data, exp_bytes[byte_idx]);
                    check_value("payload.last", payload.last, byte_idx == PAYLOAD_BYTES - 1);
                end else begin
                    check_true(1'b0, "frame carries more than six payload bytes");
                end
                if (payload.last) begin
                    frames_done++;
                    hdr_seen = 1'b0;
                    byte_idx = 0;
                    frame_open = 1'b0;
                end else begin
                    byte_idx++;
                end
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: no result after %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        adc_valid = 1'b0;
        sample = '0;
        hdr_ready = 1'b0;
        payload_ready = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        @(negedge clk);
        errs_before = error_count;
        check_value("hdr_valid", hdr_valid, 1'b0);
        check_value("payload_valid", payload_valid, 1'b0);
        check_value("ledg", ledg, 9'd0);
        for (int k = 0; k < 8; k++) begin
            check_value($sformatf("hex[%0d]", k), hex[k], expected_digit(4'h0));
        end
        finish_test("reset state", errs_before);

        for (int i = 0; i < NUM_TESTS; i++) begin
            cur = STIM_TABLE[i];
            errs_before = error_count;
            stall_limit = cur.stall;
            exp_bytes[0] = cur.m[15:8];
            exp_bytes[1] = cur.m[7:0];
            exp_bytes[2] = cur.n[15:8];
            exp_bytes[3] = cur.n[7:0];
            exp_bytes[4] = cur.adc_data[15:8];
            exp_bytes[5] = cur.adc_data[7:0];

            @(posedge clk);
            #2;
            adc_valid = 1'b1;
            sample = {cur.m, cur.n, cur.adc_data};
            @(posedge clk);
            #2;
            adc_valid = 1'b0;
            frame_open = 1'b1;

            // Second pulse lands while the frame is still in progress
            if (cur.extra_pulse) begin
                @(posedge clk);
                #2;
                adc_valid = 1'b1;
                sample = ~{cur.m, cur.n, cur.adc_data};
                @(posedge clk);
                #2;
                adc_valid = 1'b0;
            end

            while (frames_done < i + 1) begin
                @(posedge clk);
            end
            @(negedge clk);
            check_value("hdr_valid after frame", hdr_valid, 1'b0);
            check_value("payload_valid after frame", payload_valid, 1'b0);
            check_display(cur.m[15:8]);
            finish_test($sformatf("test %0d m=%h n=%h adc=%h stall=%0d extra=%0b",
                                  i, cur.m, cur.n, cur.adc_data, cur.stall,
                                  cur.extra_pulse), errs_before);
        end

        // Quiet window as long as a whole frame, a stray frame would show here
        errs_before = error_count;
        repeat ((1 + PAYLOAD_BYTES) * (MAX_STALL + 1)) @(posedge clk);
        @(negedge clk);
        check_value("frame count", frames_done, NUM_TESTS);
        check_value("header count", hdr_count, NUM_TESTS);
        finish_test("frame count", errs_before);

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== udp_sample_tx_assert.sv ====
`timescale 1ns/1ps

module framer_protocol_check
    import udp_frame_pkg::*;
(
    input logic          clk,
    input logic          rst,
    input udp_hdr_t      hdr,
    input logic          hdr_valid,
    input logic          hdr_ready,
    input payload_beat_t payload,
    input logic          payload_valid,
    input logic          payload_ready
);

    // Header held until the stack takes it
    a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        hdr_valid && !hdr_ready |=> hdr_valid && $stable(hdr))
        else $error("hdr_valid dropped or hdr changed before its transfer");

    a_payload_hold: assert property (@(posedge clk) disable iff (rst)
        payload_valid && !payload_ready |=> payload_valid && $stable(payload))
        else $error("payload_valid dropped or payload changed before its transfer");

    // Header and payload never offered together
    a_one_valid: assert property (@(posedge clk) disable iff (rst)
        !(hdr_valid && payload_valid))
        else $error("hdr_valid and payload_valid high together");

    a_reset_idle: assert property (@(posedge clk)
        rst |=> !hdr_valid && !payload_valid)
        else $error("valid high in the cycle after reset");

endmodule

bind sample_framer framer_protocol_check u_protocol_check (
    .clk           (clk),
    .rst           (rst),
    .hdr           (hdr),
    .hdr_valid     (hdr_valid),
    .hdr_ready     (hdr_ready),
    .payload       (payload),
    .payload_valid (payload_valid),
    .payload_ready (payload_ready)
);

// ==== udp_sample_tx.sv ====
`timescale 1ns/1ps

module udp_sample_tx
    import net_cfg_pkg::*;
    import udp_frame_pkg::*;
#(
    parameter logic [31:0] SRC_IP     = DEFAULT_SRC_IP,
    parameter logic [31:0] DEST_IP    = DEFAULT_DEST_IP,
    parameter logic [15:0] SRC_PORT   = DEFAULT_SRC_PORT,
    parameter logic [15:0] DEST_PORT  = DEFAULT_DEST_PORT,
    parameter logic [7:0]  TTL        = DEFAULT_TTL,
    parameter bit          SEG_INVERT = 1'b1
) (
    input  logic            clk,
    input  logic            rst,

    // Sample in
    input  logic            adc_valid,
    input  adc_sample_t     sample,

    // Header and payload towards the UDP/IP stack
    output udp_hdr_t        hdr,
    output logic            hdr_valid,
    input  logic            hdr_ready,
    output payload_beat_t   payload,
    output logic            payload_valid,
    input  logic            payload_ready,

    // Front panel
    output logic [8:0]      ledg,
    output logic [7:0][6:0] hex
);

    sample_framer #(
        .SRC_IP    (SRC_IP),
        .DEST_IP   (DEST_IP),
        .SRC_PORT  (SRC_PORT),
        .DEST_PORT (DEST_PORT),
        .TTL       (TTL)
    ) u_framer (
        .clk           (clk),
        .rst           (rst),
        .adc_valid     (adc_valid),
        .sample        (sample),
        .hdr_ready     (hdr_ready),
        .payload_ready (payload_ready),
        .hdr           (hdr),
        .hdr_valid     (hdr_valid),
        .payload       (payload),
        .payload_valid (payload_valid)
    );

    // Watches the same handshakes the stack sees
    tx_status_display #(
        .SEG_INVERT (SEG_INVERT)
    ) u_display (
        .clk           (clk),
        .rst           (rst),
        .hdr           (hdr),
        .hdr_valid     (hdr_valid),
        .hdr_ready     (hdr_ready),
        .payload       (payload),
        .payload_valid (payload_valid),
        .payload_ready (payload_ready),
        .ledg          (ledg),
        .hex           (hex)
    );

endmodule

// ==== sample_framer.sv ====
`timescale 1ns/1ps

module sample_framer
    import net_cfg_pkg::*;
    import udp_frame_pkg::*;
#(
    parameter logic [31:0] SRC_IP    = DEFAULT_SRC_IP,
    parameter logic [31:0] DEST_IP   = DEFAULT_DEST_IP,
    parameter logic [15:0] SRC_PORT  = DEFAULT_SRC_PORT,
    parameter logic [15:0] DEST_PORT = DEFAULT_DEST_PORT,
    parameter logic [7:0]  TTL       = DEFAULT_TTL
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          adc_valid,
    input  adc_sample_t   sample,
    input  logic          hdr_ready,
    input  logic          payload_ready,
    output udp_hdr_t      hdr,
    output logic          hdr_valid,
    output payload_beat_t payload,
    output logic          payload_valid
);

    localparam int IDX_W = $clog2(PAYLOAD_BYTES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(PAYLOAD_BYTES - 1);

    framer_state_e state_q;
    framer_state_e state_d;

    adc_sample_t                sample_q;
    logic [8*PAYLOAD_BYTES-1:0] sample_bytes;
    logic [IDX_W-1:0]           idx_q;

    logic hdr_xfer;
    logic payload_xfer;

    assign hdr_xfer = hdr_valid && hdr_ready;
    assign payload_xfer = payload_valid && payload_ready;

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (adc_valid) begin
                    state_d = ST_HDR;
                end
            end
            ST_HDR: begin
                if (hdr_xfer) begin
                    state_d = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                if (payload_xfer && payload.last) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            idx_q <= '0;
        end else begin
            state_q <= state_d;
            // Back to byte 0 once the last byte has gone
            if (payload_xfer) begin
                if (payload.last) begin
                    idx_q <= '0;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

    // Sample only taken while idle, pulses mid-frame are dropped
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && adc_valid) begin
            sample_q <= sample;
        end
    end

    assign sample_bytes = sample_q;

    // Most significant byte goes out first
    assign payload.data = sample_bytes[8*(PAYLOAD_BYTES-1-idx_q) +: 8];
    assign payload.last = (idx_q == LAST_IDX);

    assign hdr_valid = (state_q == ST_HDR);
    assign payload_valid = (state_q == ST_PAYLOAD);

    // UDP length counts its own 8-byte header
    assign hdr = '{
        ttl:         TTL,
        source_ip:   SRC_IP,
        dest_ip:     DEST_IP,
        source_port: SRC_PORT,
        dest_port:   DEST_PORT,
        length:      16'(UDP_HDR_BYTES + PAYLOAD_BYTES)
    };

endmodule

// ==== tx_status_display.sv ====
`timescale 1ns/1ps

module tx_status_display
    import udp_frame_pkg::*;
#(
    parameter bit SEG_INVERT = 1'b1
) (
    input  logic            clk,
    input  logic            rst,
    input  udp_hdr_t        hdr,
    input  logic            hdr_valid,
    input  logic            hdr_ready,
    input  payload_beat_t   payload,
    input  logic            payload_valid,
    input  logic            payload_ready,
    output logic [8:0]      ledg,
    output logic [7:0][6:0] hex
);

    // Set after byte 0 of a frame, cleared by the last byte
    logic        first_seen_q;
    logic [7:0]  led_q;
    logic [31:0] ip_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            first_seen_q <= 1'b0;
            led_q <= '0;
            ip_q <= '0;
        end else begin
            if (payload_valid && payload_ready) begin
                if (!first_seen_q) begin
                    led_q <= payload.data;
                end
                first_seen_q <= !payload.last;
            end
            if (hdr_valid && hdr_ready) begin
                ip_q <= hdr.dest_ip;
            end
        end
    end

    // Top LED shows a frame in flight
    assign ledg = {hdr_valid | payload_valid, led_q};

    // Digit 0 is the low nibble of the address
    seg7_decoder #(.INVERT(SEG_INVERT)) u_digit0 (.nibble(ip_q[3:0]), .segments(hex[0]));
    seg7_decoder #(.INVERT(SEG_INVERT)) u_digit1 (.nibble(ip_q[7:4]), .segments(hex[1]));
    seg7_decoder #(.INVERT(SEG_INVERT)) u_digit2 (.nibble(ip_q[11:8]), .segments(hex[2]));
    seg7_decoder #(.INVERT(SEG_INVERT)) u_digit3 (.nibble(ip_q[15:12]), .segments(hex[3]));
    seg7_decoder #(.INVERT(SEG_INVERT)) u_digit4 (.nibble(ip_q[19:16]), .segments(hex[4]));
    seg7_decoder #(.INVERT(SEG_INVERT)) u_digit5 (.nibble(ip_q[23:20]), .segments(hex[5]));
    seg7_decoder #(.INVERT(SEG_INVERT)) u_digit6 (.nibble(ip_q[27:24]), .segments(hex[6]));
    seg7_decoder #(.INVERT(SEG_INVERT)) u_digit7 (.nibble(ip_q[31:28]), .segments(hex[7]));

endmodule

// ==== seg7_decoder.sv ====
`timescale 1ns/1ps

module seg7_decoder #(
    parameter bit INVERT = 1'b1
) (
    input  logic [3:0] nibble,
    output logic [6:0] segments
);

    logic [6:0] pattern;

    // Segment a in bit 0 up to segment g in bit 6
    always_comb begin
        case (nibble)
            4'h0: pattern = 7'h3f;
            4'h1: pattern = 7'h06;
            4'h2: pattern = 7'h5b;
            4'h3: pattern = 7'h4f;
            4'h4: pattern = 7'h66;
            4'h5: pattern = 7'h6d;
            4'h6: pattern = 7'h7d;
            4'h7: pattern = 7'h07;
            4'h8: pattern = 7'h7f;
            4'h9: pattern = 7'h6f;
            4'ha: pattern = 7'h77;
            4'hb: pattern = 7'h7c;
            4'hc: pattern = 7'h39;
            4'hd: pattern = 7'h5e;
            4'he: pattern = 7'h79;
            default: pattern = 7'h71;
        endcase
    end

    // Active-low digits on the board
    assign segments = INVERT ? ~pattern : pattern;

endmodule

// ==== udp_frame_pkg.sv ====
package udp_frame_pkg;

    // One captured sample, m ends up in the most significant bits
    typedef struct packed {
        logic [15:0] m;
        logic [15:0] n;
        logic [15:0] adc_data;
    } adc_sample_t;

    // Transmit header offered to the UDP/IP stack
    typedef struct packed {
        logic [7:0]  ttl;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
    } udp_hdr_t;

    // Single byte of the payload stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } payload_beat_t;

    // Framer sequencing
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_HDR     = 2'd1,
        ST_PAYLOAD = 2'd2
    } framer_state_e;

endpackage

// ==== net_cfg_pkg.sv ====
package net_cfg_pkg;

    // Addressing used when the top level is left at its defaults
    localparam logic [31:0] DEFAULT_SRC_IP = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [31:0] DEFAULT_DEST_IP = {8'd192, 8'd168, 8'd1, 8'd100};

    localparam logic [15:0] DEFAULT_SRC_PORT = 16'd1234;
    localparam logic [15:0] DEFAULT_DEST_PORT = 16'd5678;

    // Hop limit handed to the IP layer
    localparam logic [7:0] DEFAULT_TTL = 8'd64;

    // Fixed UDP header size in bytes
    localparam int unsigned UDP_HDR_BYTES = 8;

    // Payload bytes per frame, three 16-bit values
    localparam int unsigned PAYLOAD_BYTES = 6;

endpackage
